/* rtl/max7219_pkg.sv */
package max7219_pkg;

    // One command word per device in the chain
    localparam int CMD_WIDTH = 16;

    // MAX7219 register addresses
    typedef enum logic [3:0] {
        REG_NOP       = 4'd0,
        REG_ROW0      = 4'd1,
        REG_ROW1      = 4'd2,
        REG_ROW2      = 4'd3,
        REG_ROW3      = 4'd4,
        REG_ROW4      = 4'd5,
        REG_ROW5      = 4'd6,
        REG_ROW6      = 4'd7,
        REG_ROW7      = 4'd8,
        REG_DECODE    = 4'd9,
        REG_INTENSITY = 4'd10,
        REG_SCAN      = 4'd11,
        REG_SHUTDOWN  = 4'd12,
        REG_TEST      = 4'd15
    } reg_addr_e;

    // Word as shifted out, header first
    typedef struct packed {
        logic [3:0] hdr;
        reg_addr_e  addr;
        logic [7:0] data;
    } cmd_t;

    // Init steps in the order they are sent, then the row and no-op phases
    typedef enum logic [3:0] {
        ST_SHUTDOWN, ST_NORMAL, ST_DECODE, ST_INTENSITY, ST_SCAN,
        ST_TEST_ON, ST_TEST_OFF, ST_ROWS, ST_IDLE
    } seq_state_e;

    // Leftmost and rightmost columns lit
    localparam logic [7:0] PATTERN_INIT = 8'b1000_0001;

    localparam logic [7:0] DATA_SHUT_DOWN   = 8'h00;
    localparam logic [7:0] DATA_SHUT_NORMAL = 8'h01;
    localparam logic [7:0] DATA_SCAN_ALL    = 8'h07;
    localparam logic [7:0] DATA_TEST_ON     = 8'h01;
    localparam logic [7:0] DATA_TEST_OFF    = 8'h00;
    localparam logic [7:0] DATA_DECODE_NONE = 8'h00;

endpackage

/* rtl/frame_fifo.sv */
`timescale 1ns/100ps

module frame_fifo #(
    parameter int WIDTH      = max7219_pkg::CMD_WIDTH,
    parameter int FIFO_DEPTH = 4
) (
    input  logic             i_Clk,
    input  logic             i_rst,
    input  logic             i_wr,
    input  logic [WIDTH-1:0] i_frame,
    output logic             o_full,
    input  logic             i_rd,
    output logic [WIDTH-1:0] o_frame,
    output logic             o_empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // Writes when full and reads when empty are dropped
    assign do_wr = i_wr && !o_full;
    assign do_rd = i_rd && !o_empty;

    assign o_frame = mem[rd_ptr];

    always_ff @(posedge i_Clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_frame;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            o_full  <= 1'b0;
            o_empty <= 1'b1;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10: begin
                    count   <= count + 1'b1;
                    o_empty <= 1'b0;
                    o_full  <= (count == CNT_W'(FIFO_DEPTH - 1));
                end
                2'b01: begin
                    count   <= count - 1'b1;
                    o_full  <= 1'b0;
                    o_empty <= (count == CNT_W'(1));
                end
                default: ;
            endcase
        end
    end

endmodule

/* rtl/spi_serializer.sv */
`timescale 1ns/100ps

module spi_serializer #(
    parameter int WIDTH      = max7219_pkg::CMD_WIDTH,
    parameter int SPI_CYCLES = 2
) (
    input  logic             i_Clk,
    input  logic             i_rst,
    input  logic             i_empty,
    input  logic [WIDTH-1:0] i_frame,
    output logic             o_rd,
    output logic             o_spi_load,
    output logic             o_spi_clk,
    output logic             o_spi_din
);

    localparam int HALF_W = (SPI_CYCLES > 1) ? $clog2(SPI_CYCLES) : 1;
    localparam int BIT_W  = $clog2(WIDTH);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SHIFT,
        S_HOLD
    } ser_state_e;

    ser_state_e        state;
    logic [WIDTH-1:0]  shreg;
    logic [HALF_W-1:0] half_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic              half_done;

    // Pop straight from the FIFO head while nothing is in flight
    assign o_rd      = (state == S_IDLE) && !i_empty;
    assign half_done = (half_cnt == HALF_W'(SPI_CYCLES - 1));

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            state      <= S_IDLE;
            half_cnt   <= '0;
            bit_cnt    <= '0;
            o_spi_load <= 1'b1;
            o_spi_clk  <= 1'b0;
            o_spi_din  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (o_rd) begin
                        state      <= S_SHIFT;
                        half_cnt   <= '0;
                        bit_cnt    <= '0;
                        o_spi_load <= 1'b0;
                        o_spi_din  <= i_frame[WIDTH-1];
                    end
                end
                S_SHIFT: begin
                    half_cnt <= half_done ? '0 : half_cnt + 1'b1;
                    if (half_done) begin
                        o_spi_clk <= !o_spi_clk;
                        // Falling edge ends a bit
                        if (o_spi_clk) begin
                            if (bit_cnt == BIT_W'(WIDTH - 1)) begin
                                state      <= S_HOLD;
                                o_spi_load <= 1'b1;
                                o_spi_din  <= 1'b0;
                            end else begin
                                bit_cnt   <= bit_cnt + 1'b1;
                                o_spi_din <= shreg[WIDTH-2];
                            end
                        end
                    end
                end
                default: begin
                    // Load stays high for a half period before the next frame
                    half_cnt <= half_done ? '0 : half_cnt + 1'b1;
                    if (half_done) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_Clk) begin
        if (o_rd) begin
            shreg <= i_frame;
        end else if (state == S_SHIFT && half_done && o_spi_clk) begin
            shreg <= {shreg[WIDTH-2:0], 1'b0};
        end
    end

endmodule

/* rtl/max7219_sequencer.sv */
`timescale 1ns/100ps

module max7219_sequencer #(
    parameter int N_DEVICES   = 2,
    parameter int IDLE_FRAMES = 3,
    parameter int INTENSITY   = 15
) (
    input  logic                                        i_Clk,
    input  logic                                        i_rst,
    input  logic                                        i_full,
    output logic                                        o_wr,
    output logic [N_DEVICES*max7219_pkg::CMD_WIDTH-1:0] o_frame
);

    localparam int CMD_W  = max7219_pkg::CMD_WIDTH;
    localparam int IDLE_W = (IDLE_FRAMES > 1) ? $clog2(IDLE_FRAMES) : 1;

    max7219_pkg::seq_state_e    state;
    logic [2:0]                 row;
    logic [IDLE_W-1:0]          idle_cnt;
    logic [7:0]                 pattern1;
    logic [7:0]                 pattern2;
    max7219_pkg::cmd_t          base_cmd;
    max7219_pkg::cmd_t          slot_cmd;
    logic [N_DEVICES*CMD_W-1:0] frame_next;

    // Word for the current step, as seen by even chain positions
    always_comb begin
        base_cmd = '0;
        case (state)
            max7219_pkg::ST_SHUTDOWN: begin
                base_cmd.addr = max7219_pkg::REG_SHUTDOWN;
                base_cmd.data = max7219_pkg::DATA_SHUT_DOWN;
            end
            max7219_pkg::ST_NORMAL: begin
                base_cmd.addr = max7219_pkg::REG_SHUTDOWN;
                base_cmd.data = max7219_pkg::DATA_SHUT_NORMAL;
            end
            max7219_pkg::ST_DECODE: begin
                base_cmd.addr = max7219_pkg::REG_DECODE;
                base_cmd.data = max7219_pkg::DATA_DECODE_NONE;
            end
            max7219_pkg::ST_INTENSITY: begin
                base_cmd.addr = max7219_pkg::REG_INTENSITY;
                base_cmd.data = {4'h0, 4'(INTENSITY)};
            end
            max7219_pkg::ST_SCAN: begin
                base_cmd.addr = max7219_pkg::REG_SCAN;
                base_cmd.data = max7219_pkg::DATA_SCAN_ALL;
            end
            max7219_pkg::ST_TEST_ON: begin
                base_cmd.addr = max7219_pkg::REG_TEST;
                base_cmd.data = max7219_pkg::DATA_TEST_ON;
            end
            max7219_pkg::ST_TEST_OFF: begin
                base_cmd.addr = max7219_pkg::REG_TEST;
                base_cmd.data = max7219_pkg::DATA_TEST_OFF;
            end
            max7219_pkg::ST_ROWS: begin
                base_cmd.addr = max7219_pkg::reg_addr_e'(4'(max7219_pkg::REG_ROW0) + {1'b0, row});
                base_cmd.data = pattern1;
            end
            default: begin
                base_cmd.addr = max7219_pkg::REG_NOP;
                base_cmd.data = 8'h00;
            end
        endcase
    end

    // Chain position 0 sits in the top word so it leaves first
    always_comb begin
        for (int i = 0; i < N_DEVICES; i++) begin
            slot_cmd = base_cmd;
            if (state == max7219_pkg::ST_ROWS && (i % 2) == 1) begin
                slot_cmd.data = pattern2;
            end
            frame_next[(N_DEVICES-1-i)*CMD_W +: CMD_W] = slot_cmd;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            state    <= max7219_pkg::ST_SHUTDOWN;
            row      <= '0;
            idle_cnt <= '0;
            pattern1 <= max7219_pkg::PATTERN_INIT;
            pattern2 <= max7219_pkg::PATTERN_INIT;
            o_wr     <= 1'b0;
        end else if (o_wr) begin
            // Gap cycle lets the registered full flag catch up
            o_wr <= 1'b0;
        end else if (!i_full) begin
            o_wr <= 1'b1;
            case (state)
                max7219_pkg::ST_ROWS: begin
                    pattern1 <= {pattern1[6:0], pattern1[7]};
                    pattern2 <= {pattern2[0], pattern2[7:1]};
                    row      <= row + 3'd1;
                    if (row == 3'd7) begin
                        idle_cnt <= '0;
                        state    <= max7219_pkg::ST_IDLE;
                    end
                end
                max7219_pkg::ST_IDLE: begin
                    if (idle_cnt == IDLE_W'(IDLE_FRAMES - 1)) begin
                        // Extra step between passes
                        pattern1 <= {pattern1[6:0], pattern1[7]};
                        pattern2 <= {pattern2[0], pattern2[7:1]};
                        state    <= max7219_pkg::ST_ROWS;
                    end else begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= max7219_pkg::seq_state_e'(state + 4'd1);
                end
            endcase
        end
    end

    always_ff @(posedge i_Clk) begin
        if (!o_wr && !i_full) begin
            o_frame <= frame_next;
        end
    end

endmodule

/* rtl/max7219_top.sv */
`timescale 1ns/100ps

module max7219_top #(
    parameter int N_DEVICES   = 2,
    parameter int SPI_CYCLES  = 2,
    parameter int FIFO_DEPTH  = 4,
    parameter int IDLE_FRAMES = 3,
    parameter int INTENSITY   = 15
) (
    input  logic i_Clk,
    input  logic i_rst,
    output logic o_spi_load,
    output logic o_spi_clk,
    output logic o_spi_din
);

    localparam int FRAME_W = N_DEVICES * max7219_pkg::CMD_WIDTH;

    logic               seq_wr;
    logic [FRAME_W-1:0] seq_frame;
    logic               fifo_full;
    logic               fifo_empty;
    logic [FRAME_W-1:0] fifo_frame;
    logic               ser_rd;

    max7219_sequencer #(
        .N_DEVICES   (N_DEVICES),
        .IDLE_FRAMES (IDLE_FRAMES),
        .INTENSITY   (INTENSITY)
    ) u_sequencer (
        .i_Clk   (i_Clk),
        .i_rst   (i_rst),
        .i_full  (fifo_full),
        .o_wr    (seq_wr),
        .o_frame (seq_frame)
    );

    frame_fifo #(
        .WIDTH      (FRAME_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .i_Clk   (i_Clk),
        .i_rst   (i_rst),
        .i_wr    (seq_wr),
        .i_frame (seq_frame),
        .o_full  (fifo_full),
        .i_rd    (ser_rd),
        .o_frame (fifo_frame),
        .o_empty (fifo_empty)
    );

    spi_serializer #(
        .WIDTH      (FRAME_W),
        .SPI_CYCLES (SPI_CYCLES)
    ) u_serializer (
        .i_Clk      (i_Clk),
        .i_rst      (i_rst),
        .i_empty    (fifo_empty),
        .i_frame    (fifo_frame),
        .o_rd       (ser_rd),
        .o_spi_load (o_spi_load),
        .o_spi_clk  (o_spi_clk),
        .o_spi_din  (o_spi_din)
    );

endmodule

/* testbench/max7219_tb.sv */
`timescale 1ns/100ps

module max7219_tb;

    localparam int N_DEVICES     = 2;
    localparam int IDLE_FRAMES   = 3;
    localparam int INTENSITY     = 15;
    localparam int CMD_W         = max7219_pkg::CMD_WIDTH;
    localparam int FRAME_BITS    = N_DEVICES * CMD_W;
    localparam int N_TESTS       = 6;
    localparam int LONG_RUN      = 6000;
    localparam int FRAME_TIMEOUT = 1000;

    logic i_Clk;
    logic i_rst;
    logic o_spi_load;
    logic o_spi_clk;
    logic o_spi_din;

    integer seed;
    int     errors;
    int     frames_total;
    bit     timed_out;

    // Pin decoder
    logic [FRAME_BITS-1:0] shift_bits;
    int                    bit_count;
    logic                  prev_load;
    logic                  prev_clk;

    // Reference model steps through init at 0 to 6, rows at 7 and no-ops at 8
    int         m_step;
    int         m_row;
    int         m_idle;
    logic [7:0] m_p1;
    logic [7:0] m_p2;

    max7219_top UUT (
        .i_Clk      (i_Clk),
        .i_rst      (i_rst),
        .o_spi_load (o_spi_load),
        .o_spi_clk  (o_spi_clk),
        .o_spi_din  (o_spi_din)
    );

    always #2 i_Clk = ~i_Clk;

    function automatic max7219_pkg::cmd_t make_cmd(input max7219_pkg::reg_addr_e addr,
                                                   input logic [7:0] data);
        max7219_pkg::cmd_t c;
        c.hdr  = 4'h0;
        c.addr = addr;
        c.data = data;
        return c;
    endfunction

    function automatic max7219_pkg::cmd_t expected_cmd(input int slot);
        max7219_pkg::cmd_t c;
        case (m_step)
            0: c = make_cmd(max7219_pkg::REG_SHUTDOWN, max7219_pkg::DATA_SHUT_DOWN);
            1: c = make_cmd(max7219_pkg::REG_SHUTDOWN, max7219_pkg::DATA_SHUT_NORMAL);
            2: c = make_cmd(max7219_pkg::REG_DECODE, max7219_pkg::DATA_DECODE_NONE);
            3: c = make_cmd(max7219_pkg::REG_INTENSITY, 8'(INTENSITY));
            4: c = make_cmd(max7219_pkg::REG_SCAN, max7219_pkg::DATA_SCAN_ALL);
            5: c = make_cmd(max7219_pkg::REG_TEST, max7219_pkg::DATA_TEST_ON);
            6: c = make_cmd(max7219_pkg::REG_TEST, max7219_pkg::DATA_TEST_OFF);
            7: c = make_cmd(max7219_pkg::reg_addr_e'(4'(max7219_pkg::REG_ROW0 + m_row)),
                            (slot % 2 == 0) ? m_p1 : m_p2);
            default: c = make_cmd(max7219_pkg::REG_NOP, 8'h00);
        endcase
        return c;
    endfunction

    task automatic advance_model();
        if (m_step < 7) begin
            m_step++;
        end else if (m_step == 7) begin
            m_p1 = {m_p1[6:0], m_p1[7]};
            m_p2 = {m_p2[0], m_p2[7:1]};
            if (m_row == 7) begin
                m_step = 8;
                m_idle = 0;
            end else begin
                m_row++;
            end
        end else begin
            m_idle++;
            if (m_idle == IDLE_FRAMES) begin
                // One extra rotation between passes
                m_p1   = {m_p1[6:0], m_p1[7]};
                m_p2   = {m_p2[0], m_p2[7:1]};
                m_step = 7;
                m_row  = 0;
            end
        end
    endtask

    task automatic check_cmd(input max7219_pkg::cmd_t got, input max7219_pkg::cmd_t exp,
                             input int slot);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: o_spi_din word[%0d] got %h expected %h",
                     $time, slot, got, exp);
        end
    endtask

    task automatic check_bits(input int got);
        if (got != FRAME_BITS) begin
            errors++;
            $display("Error at %0t ns: o_spi_clk rising edges got %0d expected %0d",
                     $time, got, FRAME_BITS);
        end
    endtask

    task automatic check_pin(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic finish_frame();
        max7219_pkg::cmd_t got;
        check_bits(bit_count);
        // Position 0 was shifted first, so it ends up in the top word
        for (int s = 0; s < N_DEVICES; s++) begin
            got = max7219_pkg::cmd_t'(shift_bits[(N_DEVICES-1-s)*CMD_W +: CMD_W]);
            check_cmd(got, expected_cmd(s), s);
        end
        advance_model();
        frames_total++;
    endtask

    task automatic apply_reset();
        @(posedge i_Clk);
        i_rst <= 1'b1;
        repeat (7) @(posedge i_Clk);
        @(negedge i_Clk);
        check_pin("o_spi_load", o_spi_load, 1'b1);
        check_pin("o_spi_clk", o_spi_clk, 1'b0);
        check_pin("o_spi_din", o_spi_din, 1'b0);
        @(posedge i_Clk);
        i_rst <= 1'b0;
        m_step    = 0;
        m_row     = 0;
        m_idle    = 0;
        m_p1      = max7219_pkg::PATTERN_INIT;
        m_p2      = max7219_pkg::PATTERN_INIT;
        prev_load = 1'b1;
        prev_clk  = 1'b0;
        bit_count = 0;
    endtask

    // Watch the pins for a number of cycles, checking every frame that ends
    task automatic run_window(input int cycles, output int frames);
        int quiet;
        frames = 0;
        quiet  = 0;
        for (int c = 0; c < cycles && !timed_out; c++) begin
            @(negedge i_Clk);
            quiet++;
            if (o_spi_load !== prev_load) begin
                check_pin("o_spi_clk at load edge", o_spi_clk, 1'b0);
            end
            if (!o_spi_load && prev_load) begin
                bit_count = 0;
            end
            if (!o_spi_load && !prev_clk && o_spi_clk) begin
                shift_bits = {shift_bits[FRAME_BITS-2:0], o_spi_din};
                bit_count++;
            end
            if (o_spi_load && !prev_load) begin
                finish_frame();
                frames++;
                quiet = 0;
            end
            prev_load = o_spi_load;
            prev_clk  = o_spi_clk;
            if (quiet > FRAME_TIMEOUT) begin
                timed_out = 1'b1;
                $display("Timeout: no frame finished within %0d cycles", FRAME_TIMEOUT);
            end
        end
    endtask

    initial begin
        int gap;
        int frames;
        int err_before;
        i_Clk        = 1'b0;
        i_rst        = 1'b1;
        seed         = 26;
        errors       = 0;
        frames_total = 0;
        timed_out    = 1'b0;
        for (int t = 0; t < N_TESTS && !timed_out; t++) begin
            err_before = errors;
            apply_reset();
            // Last run is long enough to see a second pass of rows
            if (t == N_TESTS - 1) begin
                gap = LONG_RUN;
            end else begin
                gap = 200 + ({$random(seed)} % 2801);
            end
            run_window(gap, frames);
            $display("Test %0d: %0d cycles after reset, %0d frames, %0d errors",
                     t, gap, frames, errors - err_before);
        end
        $display("Summary: %0d frames checked, %0d errors, timeout %0d",
                 frames_total, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* compile.f */
rtl/max7219_pkg.sv
rtl/frame_fifo.sv
rtl/spi_serializer.sv
rtl/max7219_sequencer.sv
rtl/max7219_top.sv
testbench/max7219_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f compile.f --top-module max7219_tb -o max7219_sim \
    || { echo "Build failed"; exit 1; }
./obj_dir/max7219_sim | tee /dev/stderr | grep -qx "No errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
